//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FM interface testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module fm_iface_tb \
	--Mdir obj_dir -o fm_iface_sim

# A failing run exits non-zero, so the log decides the result.
./obj_dir/fm_iface_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
	echo "Simulation FAILED, see sim.log"
	exit 1
fi
echo "Simulation PASSED"

//--- source/fm_cpu_sync.sv
`timescale 1ns/1ps

module fm_cpu_sync (
	input  logic       cpu_clk,
	input  logic       rst,
	input  logic [7:0] cpu_din,
	input  logic [1:0] cpu_addr,
	input  logic       cpu_cs_n,
	input  logic       cpu_wr_n,
	output logic [7:0] cpu_dout,
	output logic       cpu_irq_n,
	input  logic       syn_clk,
	output logic       syn_rst,
	output logic       syn_toggle,
	output logic [1:0] syn_port,
	output logic [7:0] syn_data,
	input  logic       syn_busy,
	input  logic       flag_a,
	input  logic       flag_b,
	input  logic       irq_n
);

	logic       rst_meta;   // First stage of the synthesizer reset.
	logic       write_raw;  // Strobe condition, cs_n and wr_n both low.
	logic       write_q;    // Strobe condition one cycle back.
	logic       write_edge; // Start of a CPU write.
	logic       cpu_busy;   // Busy bit seen by the CPU.
	logic [2:0] busy_sync;  // Two sync stages plus edge flop for syn_busy.
	logic       busy_fall;
	logic [2:0] stat_s1;    // {flag_b, flag_a, irq_n}, first stage.
	logic [2:0] stat_s2;    // Second stage, used by the CPU side.

	// Reset for the synthesizer domain, rst seen through two syn_clk flops.
	always_ff @(posedge syn_clk) begin
		rst_meta <= rst;
		syn_rst  <= rst_meta;
	end

	assign write_raw  = !cpu_cs_n && !cpu_wr_n;
	assign write_edge = write_raw && !write_q; // Holding the strobe gives one write.
	assign busy_fall  = busy_sync[2] && !busy_sync[1];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			write_q    <= 1'b0;
			syn_toggle <= 1'b0;
			cpu_busy   <= 1'b0;
			busy_sync  <= 3'b000;
			stat_s1    <= 3'b001; // Flags clear, irq_n high.
			stat_s2    <= 3'b001;
		end else begin
			write_q   <= write_raw;
			busy_sync <= {busy_sync[1:0], syn_busy};
			stat_s1   <= {flag_b, flag_a, irq_n};
			stat_s2   <= stat_s1;
			if (busy_fall)
				cpu_busy <= 1'b0; // Synthesizer side finished the write.
			if (write_edge) begin
				cpu_busy   <= 1'b1; // A new write wins over a late clear.
				syn_toggle <= ~syn_toggle;
			end
		end
	end

	// Port and data are held until the next write.
	always_ff @(posedge cpu_clk) begin
		if (write_edge) begin
			syn_port <= cpu_addr;
			syn_data <= cpu_din;
		end
	end

	// Status byte does not depend on the address.
	assign cpu_dout  = cpu_cs_n ? 8'hFF : {cpu_busy, 5'b00000, stat_s2[2], stat_s2[1]};
	assign cpu_irq_n = stat_s2[0];

	// The toggle only flips for a detected write edge.
	a_toggle_on_write: assert property (
		@(posedge cpu_clk) disable iff (rst)
		$changed(syn_toggle) |-> $past(write_edge)
	);

endmodule

//--- source/fm_iface_top.sv
`timescale 1ns/1ps

module fm_iface_top #(
	parameter int BUSY_CYCLES = 8, // syn_clk cycles of busy per write.
	parameter int TIMER_PRESC = 4  // syn_clk cycles per timer tick.
) (
	input  logic       cpu_clk,
	input  logic       syn_clk,
	input  logic       rst,
	input  logic [7:0] cpu_din,
	input  logic [1:0] cpu_addr,
	input  logic       cpu_cs_n,
	input  logic       cpu_wr_n,
	output logic [7:0] cpu_dout,
	output logic       cpu_irq_n
);

	logic       syn_rst;
	logic       syn_toggle;
	logic [1:0] syn_port;
	logic [7:0] syn_data;
	logic       syn_busy;
	logic       flag_a, flag_b, irq_n;

	fm_reg_bus_if reg_bus (); // Decoded register writes, syn_clk domain.

	// CPU bus to synthesizer clock domain.
	fm_cpu_sync u_cpu_sync (
		.cpu_clk    (cpu_clk),
		.rst        (rst),
		.cpu_din    (cpu_din),
		.cpu_addr   (cpu_addr),
		.cpu_cs_n   (cpu_cs_n),
		.cpu_wr_n   (cpu_wr_n),
		.cpu_dout   (cpu_dout),
		.cpu_irq_n  (cpu_irq_n),
		.syn_clk    (syn_clk),
		.syn_rst    (syn_rst),
		.syn_toggle (syn_toggle),
		.syn_port   (syn_port),
		.syn_data   (syn_data),
		.syn_busy   (syn_busy),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq_n      (irq_n)
	);

	fm_write_port #(.BUSY_CYCLES(BUSY_CYCLES)) u_write_port (
		.syn_clk    (syn_clk),
		.syn_rst    (syn_rst),
		.syn_toggle (syn_toggle),
		.syn_port   (syn_port),
		.syn_data   (syn_data),
		.syn_busy   (syn_busy),
		.reg_bus    (reg_bus.src)
	);

	fm_timers #(.TIMER_PRESC(TIMER_PRESC)) u_timers (
		.syn_clk (syn_clk),
		.syn_rst (syn_rst),
		.reg_bus (reg_bus.dst),
		.flag_a  (flag_a),
		.flag_b  (flag_b),
		.irq_n   (irq_n)
	);

endmodule

//--- source/fm_pkg.sv
package fm_pkg;

	// Register number inside one bank.
	typedef logic [7:0] fm_addr_t;

	// Meaning of register 0x27, the timer control word.
	typedef struct packed {
		logic [1:0] mode;       // Channel 3 mode, not handled here.
		logic       rst_flag_b; // Clears flag B when written as 1.
		logic       rst_flag_a; // Clears flag A when written as 1.
		logic       en_flag_b;  // Overflow of B may set flag B.
		logic       en_flag_a;  // Overflow of A may set flag A.
		logic       load_b;     // Runs timer B.
		logic       load_a;     // Runs timer A.
	} fm_ctrl_t;

	// One data byte of a register write.
	// Timer values read it raw, the control register reads the fields.
	typedef union packed {
		logic [7:0] raw;
		fm_ctrl_t   ctrl;
	} fm_reg_data_u;

	// Timer register map, bank I.
	localparam fm_addr_t REG_TIMER_A_HI = 8'h24; // Timer A bits 9..2.
	localparam fm_addr_t REG_TIMER_A_LO = 8'h25; // Timer A bits 1..0.
	localparam fm_addr_t REG_TIMER_B    = 8'h26; // Timer B, 8 bits.
	localparam fm_addr_t REG_TIMER_CTRL = 8'h27; // Load, enable and reset bits.

	// Timer B ticks once every 16 prescaler ticks.
	localparam int TIMER_B_DIV = 16;

endpackage

//--- source/fm_reg_bus_if.sv
`timescale 1ns/1ps

// One decoded register write, valid for a single syn_clk cycle.
interface fm_reg_bus_if;
	import fm_pkg::*;

	logic         wr;   // Write strobe, one cycle.
	logic         bank; // 0 is bank I, 1 is bank II.
	fm_addr_t     addr; // Register number from the address latch.
	fm_reg_data_u data; // Data byte of the write.

	// Write port side.
	modport src (
		output wr, bank, addr, data
	);

	// Register consumers.
	modport dst (
		input wr, bank, addr, data
	);

endinterface

//--- source/fm_timers.sv
`timescale 1ns/1ps

module fm_timers #(
	parameter int TIMER_PRESC = 4
) (
	input  logic      syn_clk,
	input  logic      syn_rst,
	fm_reg_bus_if.dst reg_bus,
	output logic      flag_a,
	output logic      flag_b,
	output logic      irq_n
);
	import fm_pkg::*;

	localparam int DIV_B = TIMER_PRESC * TIMER_B_DIV; // syn_clk per B tick.
	localparam int PA_W  = $clog2(TIMER_PRESC) + 1;
	localparam int PB_W  = $clog2(DIV_B) + 1;

	logic [9:0]      val_a;  // Reload value of A.
	logic [7:0]      val_b;  // Reload value of B.
	logic [9:0]      cnt_a;
	logic [7:0]      cnt_b;
	logic [PA_W-1:0] presc_a;
	logic [PB_W-1:0] presc_b;
	logic            load_a, load_b; // Timer running.
	logic            en_a, en_b;     // Flag enables.
	logic            wr_bank1, wr_ctrl;
	fm_ctrl_t        ctrl_in;
	logic            start_a, start_b;
	logic            tick_a, tick_b;
	logic            ovf_a, ovf_b;

	assign wr_bank1 = reg_bus.wr && !reg_bus.bank; // Bank II writes are ignored.
	assign wr_ctrl  = wr_bank1 && (reg_bus.addr == REG_TIMER_CTRL);
	assign ctrl_in  = reg_bus.data.ctrl;

	// A rising load bit starts the counter from its value.
	assign start_a = wr_ctrl && ctrl_in.load_a && !load_a;
	assign start_b = wr_ctrl && ctrl_in.load_b && !load_b;

	assign tick_a = load_a && (presc_a == PA_W'(TIMER_PRESC - 1));
	assign tick_b = load_b && (presc_b == PB_W'(DIV_B - 1));
	assign ovf_a  = tick_a && (cnt_a == 10'h3FF);
	assign ovf_b  = tick_b && (cnt_b == 8'hFF);

	always_ff @(posedge syn_clk) begin
		if (syn_rst) begin
			load_a  <= 1'b0;
			load_b  <= 1'b0;
			en_a    <= 1'b0;
			en_b    <= 1'b0;
			flag_a  <= 1'b0;
			flag_b  <= 1'b0;
			presc_a <= '0;
			presc_b <= '0;
		end else begin
			// Prescalers restart whenever their timer is stopped.
			presc_a <= (!load_a || tick_a) ? '0 : presc_a + 1'b1;
			presc_b <= (!load_b || tick_b) ? '0 : presc_b + 1'b1;
			if (wr_ctrl) begin
				load_a <= ctrl_in.load_a; // Clearing the bit stops the timer.
				load_b <= ctrl_in.load_b;
				en_a   <= ctrl_in.en_flag_a;
				en_b   <= ctrl_in.en_flag_b;
			end
			if (ovf_a && en_a)
				flag_a <= 1'b1;
			if (ovf_b && en_b)
				flag_b <= 1'b1;
			if (wr_ctrl && ctrl_in.rst_flag_a)
				flag_a <= 1'b0; // Reset bit wins over a same-cycle overflow.
			if (wr_ctrl && ctrl_in.rst_flag_b)
				flag_b <= 1'b0;
		end
	end

	// Values and counters.
	always_ff @(posedge syn_clk) begin
		if (wr_bank1) begin
			case (reg_bus.addr)
				REG_TIMER_A_HI: val_a[9:2] <= reg_bus.data.raw;
				REG_TIMER_A_LO: val_a[1:0] <= reg_bus.data.raw[1:0];
				REG_TIMER_B:    val_b      <= reg_bus.data.raw;
				default: ;
			endcase
		end
		if (start_a || ovf_a)
			cnt_a <= val_a; // Reload on start and on overflow.
		else if (tick_a)
			cnt_a <= cnt_a + 1'b1;
		if (start_b || ovf_b)
			cnt_b <= val_b;
		else if (tick_b)
			cnt_b <= cnt_b + 1'b1;
	end

	assign irq_n = !(flag_a || flag_b); // Low while either flag is set.

	// Flags only rise when their enable bit was set.
	a_flag_a_enabled: assert property (
		@(posedge syn_clk) disable iff (syn_rst)
		$rose(flag_a) |-> $past(en_a)
	);

	a_flag_b_enabled: assert property (
		@(posedge syn_clk) disable iff (syn_rst)
		$rose(flag_b) |-> $past(en_b)
	);

endmodule

//--- source/fm_write_port.sv
`timescale 1ns/1ps

module fm_write_port #(
	parameter int BUSY_CYCLES = 8
) (
	input  logic       syn_clk,
	input  logic       syn_rst,
	input  logic       syn_toggle,
	input  logic [1:0] syn_port,
	input  logic [7:0] syn_data,
	output logic       syn_busy,
	fm_reg_bus_if.src  reg_bus
);
	import fm_pkg::*;

	localparam int CNT_W = $clog2(BUSY_CYCLES + 1);

	logic [1:0]       tog_sync;   // Two-stage synchronizer for the toggle.
	logic             tog_q;      // Edge flop.
	logic             tog_edge;   // One write arrived from the CPU side.
	logic [CNT_W-1:0] busy_cnt;   // Busy down-counter.
	fm_addr_t         addr_lat [2]; // Address latch per bank.

	assign tog_edge = tog_sync[1] ^ tog_q;

	always_ff @(posedge syn_clk) begin
		if (syn_rst) begin
			tog_sync   <= 2'b00;
			tog_q      <= 1'b0;
			reg_bus.wr <= 1'b0;
			busy_cnt   <= '0;
		end else begin
			tog_sync   <= {tog_sync[0], syn_toggle};
			tog_q      <= tog_sync[1];
			reg_bus.wr <= tog_edge && syn_port[0]; // Odd port is a data write.
			if (tog_edge)
				busy_cnt <= CNT_W'(BUSY_CYCLES); // Every write restarts busy.
			else if (busy_cnt != '0)
				busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// Latches and the write payload.
	always_ff @(posedge syn_clk) begin
		if (tog_edge) begin
			if (!syn_port[0]) begin
				addr_lat[syn_port[1]] <= syn_data; // Port 0 or 2 selects a register.
			end else begin
				reg_bus.bank     <= syn_port[1];
				reg_bus.addr     <= addr_lat[syn_port[1]];
				reg_bus.data.raw <= syn_data;
			end
		end
	end

	assign syn_busy = (busy_cnt != '0);

	// No register write leaves the port while the domain is in reset.
	a_no_wr_in_reset: assert property (
		@(posedge syn_clk)
		syn_rst |=> !reg_bus.wr
	);

	// Busy covers every write the consumers see.
	a_wr_busy: assert property (
		@(posedge syn_clk) disable iff (syn_rst)
		reg_bus.wr |-> syn_busy
	);

endmodule

//--- sources.f
source/fm_pkg.sv
source/fm_reg_bus_if.sv
source/fm_cpu_sync.sv
source/fm_write_port.sv
source/fm_timers.sv
source/fm_iface_top.sv
verif/fm_iface_tb.sv

//--- verif/fm_iface_tb.sv
`timescale 1ns/1ps

module fm_iface_tb;
	import fm_pkg::*;

	localparam int BUSY_CYCLES    = 8;
	localparam int TIMER_PRESC    = 4;
	localparam int CPU_PERIOD     = 10; // ns.
	localparam int SYN_PERIOD     = 14; // ns.
	localparam int B_DIV          = 16; // Timer B counts once per 16 prescaler ticks.
	localparam int BUSY_LIMIT     = BUSY_CYCLES * SYN_PERIOD / CPU_PERIOD + 10;
	localparam int TIMEOUT_CYCLES = 20000; // About 4x the summed timer windows.

	logic        cpu_clk = 1'b0;
	logic        syn_clk = 1'b0;
	logic        rst;
	logic [7:0]  cpu_din;
	logic [1:0]  cpu_addr;
	logic        cpu_cs_n;
	logic        cpu_wr_n;
	logic [7:0]  cpu_dout;
	logic        cpu_irq_n;
	logic [31:0] rand_state = 32'h7824c380;
	int          cycle_cnt = 0;
	realtime     write_time; // Clock edge that saw the last write strobe.

	fm_iface_top #(.BUSY_CYCLES(BUSY_CYCLES), .TIMER_PRESC(TIMER_PRESC)) i_dut (
		.cpu_clk   (cpu_clk),
		.syn_clk   (syn_clk),
		.rst       (rst),
		.cpu_din   (cpu_din),
		.cpu_addr  (cpu_addr),
		.cpu_cs_n  (cpu_cs_n),
		.cpu_wr_n  (cpu_wr_n),
		.cpu_dout  (cpu_dout),
		.cpu_irq_n (cpu_irq_n)
	);

	always #(CPU_PERIOD / 2) cpu_clk = ~cpu_clk;
	always #(SYN_PERIOD / 2) syn_clk = ~syn_clk; // Unrelated to cpu_clk.

	always @(posedge cpu_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("simulation ran past its cycle limit without finishing");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Next random number below span.
	function automatic int draw_below(input int span);
		rand_state = xorshift32(rand_state);
		return int'(rand_state % span);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_status(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			abort_run($sformatf("ERROR: cpu_dout %s expected 0x%02h actual 0x%02h",
				name, exp, act));
	endtask

	task automatic check_irq(input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("ERROR: cpu_irq_n expected 0x%01h actual 0x%01h", exp, act));
	endtask

	// One status read, sampled mid-cycle. cs_n stays low afterwards.
	task automatic read_status(output logic [7:0] st, output logic irq);
		@(posedge cpu_clk);
		cpu_cs_n <= 1'b0;
		@(negedge cpu_clk);
		st  = cpu_dout;
		irq = cpu_irq_n;
	endtask

	// Deselected bus for n cycles, data out must float high.
	task automatic idle_gap(input int n);
		@(posedge cpu_clk);
		cpu_cs_n <= 1'b1;
		repeat (n) begin
			@(negedge cpu_clk);
			check_status("deselected", 8'hFF, cpu_dout);
		end
	endtask

	// Strobe one write, then poll busy until it drops.
	task automatic cpu_write(input logic [1:0] port, input logic [7:0] data);
		logic [7:0] st;
		logic       irq;
		int         n;
		@(posedge cpu_clk);
		cpu_cs_n <= 1'b0;
		cpu_wr_n <= 1'b0;
		cpu_addr <= port;
		cpu_din  <= data;
		@(posedge cpu_clk);
		cpu_wr_n   <= 1'b1;
		write_time = $realtime; // Toggle flips on this edge.
		n = 0;
		read_status(st, irq);
		check_status("status busy", 8'h80, st & 8'h80);
		while (st[7]) begin
			n++;
			if (n > BUSY_LIMIT)
				abort_run("busy bit did not clear in time after a write");
			read_status(st, irq);
		end
	endtask

	// Bank II writes to the timer registers.
	task automatic bank2_noise(input int n);
		logic [7:0] st;
		logic       irq_v;
		repeat (n) begin
			cpu_write(2'd2, REG_TIMER_A_HI + fm_addr_t'(draw_below(4)));
			cpu_write(2'd3, 8'(draw_below(256)));
			idle_gap(1 + draw_below(4));
		end
		read_status(st, irq_v);
		check_status("status busy/flag_b/flag_a", 8'h00, st);
		check_irq(1'b1, irq_v);
	endtask

	// Load, wait for the flag, clear it, then watch a masked window.
	// Bank II noise lands between the value writes and the start.
	task automatic run_timer(input logic is_b, input int value, input int noise_n);
		logic [7:0] st;
		logic       irq_v;
		logic [7:0] mask;
		logic [7:0] go_word;
		logic [7:0] clr_word;
		real        period;
		real        limit;
		realtime    t0;
		mask     = is_b ? 8'h02 : 8'h01;
		go_word  = is_b ? 8'h0A : 8'h05; // Load plus flag enable.
		clr_word = is_b ? 8'h22 : 8'h11; // Keeps running, clears the flag, drops enable.
		if (is_b)
			period = real'((256 - value) * B_DIV * TIMER_PRESC * SYN_PERIOD);
		else
			period = real'((1024 - value) * TIMER_PRESC * SYN_PERIOD);
		limit = 2.0 * period + real'(20 * CPU_PERIOD); // Sync latency margin.
		if (is_b) begin
			cpu_write(2'd0, REG_TIMER_B);
			cpu_write(2'd1, value[7:0]);
		end else begin
			cpu_write(2'd0, REG_TIMER_A_HI);
			cpu_write(2'd1, value[9:2]);
			cpu_write(2'd0, REG_TIMER_A_LO);
			cpu_write(2'd1, {6'd0, value[1:0]});
		end
		if (noise_n > 0)
			bank2_noise(noise_n);
		cpu_write(2'd0, REG_TIMER_CTRL);
		cpu_write(2'd1, go_word);
		t0 = write_time;
		read_status(st, irq_v);
		while ((st & mask) == 8'h00) begin
			check_status("status busy/flag_b/flag_a", 8'h00, st);
			check_irq(1'b1, irq_v);
			if ($realtime - t0 > limit)
				abort_run("timer flag was not set within its window");
			read_status(st, irq_v);
		end
		if ($realtime - t0 < period)
			abort_run("timer flag was set before one full period had passed");
		check_status("status busy/flag_b/flag_a", mask, st);
		check_irq(1'b0, irq_v);
		cpu_write(2'd1, clr_word); // Address latch still holds 0x27.
		t0 = $realtime;
		while ($realtime - t0 < limit) begin
			read_status(st, irq_v);
			check_status("status busy/flag_b/flag_a", 8'h00, st);
			check_irq(1'b1, irq_v);
		end
		cpu_write(2'd1, 8'h30); // Stop both timers.
	endtask

	initial begin
		logic [7:0] st;
		logic       irq_v;
		rst      = 1'b1;
		cpu_din  = 8'h00;
		cpu_addr = 2'd0;
		cpu_cs_n = 1'b1;
		cpu_wr_n = 1'b1;
		repeat (16) @(posedge cpu_clk);
		rst <= 1'b0;
		repeat (4) @(posedge cpu_clk); // Synthesizer reset trails by two syn_clk.
		idle_gap(3);
		read_status(st, irq_v);
		check_status("status after reset", 8'h00, st);
		check_irq(1'b1, irq_v);
		for (int r = 0; r < 2; r++) begin
			idle_gap(1 + draw_below(8));
			run_timer(1'b0, 1000 + draw_below(24), 0);
			idle_gap(1 + draw_below(8));
			run_timer(1'b1, 250 + draw_below(6), 0);
		end
		run_timer(1'b0, 1000 + draw_below(24), 3);
		run_timer(1'b1, 250 + draw_below(6), 3);
		idle_gap(2);
		$display("all tests passed");
		$finish;
	end

endmodule
